//--- compile.f
logic/audio_pkg.sv
logic/sample_counter.sv
logic/offset_fsm.sv
logic/dc_offset_remover.sv
logic/antialias_decimator.sv
logic/audio_front_end.sv
tests/audio_front_end_asserts.sv
tests/audio_front_end_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=audio_front_end_tb
EXE=sim_$TOP

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -Mdir "$BUILD_DIR" -o "$EXE" -f compile.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

# the log decides pass or fail
if grep -q "^Finished with no errors$" "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
fi

echo "pass message not found in $LOG_FILE"
exit 1

//--- tests/audio_front_end_tb.sv
`timescale 1ns/1ns
`default_nettype none

module audio_front_end_tb;

    import audio_pkg::*;

    logic          audio_clk;
    logic          rst_in;
    logic          offset_trigger;
    audio_sample_t mic_in;
    audio_sample_t processed;
    sample_t       offset_value;
    logic          offset_ready;

    int            cycle;
    string         current_test;
    logic [31:0]   rng_state;
    sample_t       meas_vals [16];

    // reference model state
    int            model_offset;
    int            model_hist [4];
    int            model_phase;
    int            exp_data_q [$];
    int            exp_cycle_q [$];
    int            exp_data;
    int            exp_cycle;
    int            last_data;
    logic          ready_seen;

    audio_front_end dut (
        .audio_clk      (audio_clk),
        .rst_in         (rst_in),
        .offset_trigger (offset_trigger),
        .mic_in         (mic_in),
        .processed      (processed),
        .offset_value   (offset_value),
        .offset_ready   (offset_ready)
    );

    always #4 audio_clk = ~audio_clk;

    always @(posedge audio_clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int clamp16(input int value);
        if (value > 32767) begin
            return 32767;
        end else if (value < -32768) begin
            return -32768;
        end
        return value;
    endfunction

    // rounds toward minus infinity
    function automatic int floor_div16(input int value);
        if (value >= 0) begin
            return value / 16;
        end
        return -((-value + 15) / 16);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string name, input int expected, input int actual);
        if (expected != actual) begin
            abort_run($sformatf("error: %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    // one strobe through subtraction, FIR and decimation
    task automatic model_sample(input sample_t value, input int visible_cycle);
        int clean;
        int sum;
        clean = clamp16(int'(value) - model_offset);
        sum = clean + 4 * model_hist[0] + 6 * model_hist[1] + 4 * model_hist[2]
            + model_hist[3];
        model_hist[3] = model_hist[2];
        model_hist[2] = model_hist[1];
        model_hist[1] = model_hist[0];
        model_hist[0] = clean;
        if (model_phase == 0) begin
            exp_data_q.push_back(clamp16(floor_div16(sum)));
            exp_cycle_q.push_back(visible_cycle + 2);
        end
        model_phase = (model_phase + 1) % 2;
    endtask

    task automatic send_sample(input sample_t value);
        @(posedge audio_clk);
        offset_trigger <= 1'b0;
        mic_in.valid   <= 1'b1;
        mic_in.data    <= value;
        // the DUT sees it in the cycle after this edge
        model_sample(value, cycle + 1);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge audio_clk);
            offset_trigger <= 1'b0;
            mic_in.valid   <= 1'b0;
        end
    endtask

    task automatic pulse_trigger();
        @(posedge audio_clk);
        offset_trigger <= 1'b1;
        mic_in.valid   <= 1'b0;
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        idle_cycles(1);
        while (exp_data_q.size() != 0) begin
            if (waited == 16) begin
                abort_run($sformatf("%s: expected outputs did not arrive in time",
                    current_test));
            end
            idle_cycles(1);
            waited++;
        end
        idle_cycles(4);
    endtask

    // trigger, 16 strobes from meas_vals, then wait for the new offset
    task automatic run_measurement(input int gap);
        int   sum;
        int   expected;
        int   waited;
        logic loaded;
        sum = 0;
        for (int i = 0; i < 16; i++) begin
            sum = sum + int'(meas_vals[i]);
        end
        expected = floor_div16(sum);
        pulse_trigger();
        for (int i = 0; i < 16; i++) begin
            send_sample(meas_vals[i]);
            if (i < 15) begin
                idle_cycles(gap);
            end
        end
        waited = 0;
        loaded = 1'b0;
        while (!loaded) begin
            if (waited == 2) begin
                check_equal({current_test, " offset_value"}, expected, int'(offset_value));
                check_equal({current_test, " offset_ready"}, 1, int'(offset_ready));
            end
            idle_cycles(1);
            @(negedge audio_clk);
            waited++;
            loaded = offset_ready && (int'(offset_value) == expected);
        end
        model_offset = expected;
    endtask

    always @(negedge audio_clk) begin
        if (!rst_in) begin
            if (processed.valid) begin
                if (exp_data_q.size() == 0) begin
                    abort_run($sformatf("%s: processed strobe with no expected sample",
                        current_test));
                end else begin
                    exp_data  = exp_data_q.pop_front();
                    exp_cycle = exp_cycle_q.pop_front();
                    last_data = int'($signed(processed.data));
                    check_equal({current_test, " data"}, exp_data, last_data);
                    check_equal({current_test, " latency"}, exp_cycle, cycle);
                end
            end
            if (offset_ready) begin
                ready_seen = 1'b1;
            end else if (ready_seen) begin
                abort_run("offset_ready fell after an offset was loaded");
            end
        end
    end

    task automatic test_reset_state();
        current_test = "reset_state";
        @(negedge audio_clk);
        check_equal("reset_state processed.valid", 0, int'(processed.valid));
        check_equal("reset_state offset_ready", 0, int'(offset_ready));
        check_equal("reset_state offset_value", 0, int'(offset_value));
        // any strobe here has no expected entry
        idle_cycles(20);
    endtask

    task automatic test_filter_decimation();
        current_test = "filter_decimation";
        send_sample(16'sd16000);
        for (int i = 0; i < 8; i++) begin
            send_sample(16'sd0);
        end
        for (int i = 0; i < 12; i++) begin
            send_sample(16'sd1000);
            idle_cycles(1);
        end
        drain_outputs();
        check_equal("filter_decimation settle", 1000, last_data);
    endtask

    task automatic test_offset_measurement();
        current_test = "offset_measurement";
        // sum is -728, so the floor of the average is -46
        for (int i = 0; i < 16; i++) begin
            meas_vals[i] = sample_t'(37 - 11 * i);
        end
        run_measurement(1);
        check_equal("offset_measurement offset_value", -46, int'(offset_value));
        drain_outputs();
    endtask

    task automatic test_random_offset_removal();
        current_test = "random_offset_removal";
        for (int i = 0; i < 200; i++) begin
            rng_state = xorshift32(rng_state);
            send_sample($signed(rng_state[15:0]));
            if (!rng_state[18]) begin
                idle_cycles(int'(rng_state[17:16]) + 1);
            end
        end
        drain_outputs();
    endtask

    task automatic test_remeasurement();
        current_test = "remeasurement";
        for (int i = 0; i < 16; i++) begin
            meas_vals[i] = -16'sd1234;
        end
        run_measurement(0);
        check_equal("remeasurement offset_value", -1234, int'(offset_value));
        for (int i = 0; i < 10; i++) begin
            send_sample(sample_t'(i * 300 - 1500));
            idle_cycles(i % 2);
        end
        drain_outputs();
    endtask

    task automatic test_saturation();
        current_test = "saturation";
        for (int i = 0; i < 16; i++) begin
            meas_vals[i] = -16'sd30000;
        end
        run_measurement(0);
        for (int i = 0; i < 8; i++) begin
            send_sample(sample_t'(30000 + i * 300));
        end
        drain_outputs();
        check_equal("saturation upper", 32767, last_data);
        for (int i = 0; i < 16; i++) begin
            meas_vals[i] = 16'sd30000;
        end
        run_measurement(0);
        for (int i = 0; i < 8; i++) begin
            send_sample(sample_t'(-30000 - i * 300));
        end
        drain_outputs();
        check_equal("saturation lower", -32768, last_data);
    endtask

    initial begin
        audio_clk      = 1'b0;
        rst_in         <= 1'b1;
        offset_trigger <= 1'b0;
        mic_in         <= '0;
        rng_state      = 32'd60742;
        model_offset   = 0;
        model_phase    = 0;
        last_data      = 0;
        ready_seen     = 1'b0;
        current_test   = "reset";
        for (int i = 0; i < 4; i++) begin
            model_hist[i] = 0;
        end
        repeat (16) @(posedge audio_clk);
        rst_in <= 1'b0;

        test_reset_state();
        test_filter_decimation();
        test_offset_measurement();
        test_random_offset_removal();
        test_remeasurement();
        test_saturation();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/audio_front_end_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module audio_front_end_asserts (
    input wire                            audio_clk,
    input wire                            rst_in,
    input wire audio_pkg::audio_sample_t  mic_in,
    input wire audio_pkg::audio_sample_t  processed,
    input wire logic                      offset_ready
);

    // decimation by two leaves a gap after every kept sample
    no_back_to_back: assert property (@(posedge audio_clk) disable iff (rst_in)
        processed.valid |=> !processed.valid)
        else $error("processed.valid high on two consecutive cycles");

    // two register stages between input and output
    output_follows_input: assert property (@(posedge audio_clk) disable iff (rst_in)
        processed.valid |-> $past(mic_in.valid, 2))
        else $error("processed.valid without mic_in.valid two cycles earlier");

    ready_is_sticky: assert property (@(posedge audio_clk) disable iff (rst_in)
        offset_ready |=> offset_ready)
        else $error("offset_ready fell outside reset");

endmodule

bind audio_front_end audio_front_end_asserts u_asserts (
    .audio_clk    (audio_clk),
    .rst_in       (rst_in),
    .mic_in       (mic_in),
    .processed    (processed),
    .offset_ready (offset_ready)
);

`default_nettype wire

//--- logic/audio_front_end.sv
`timescale 1ns/1ns
`default_nettype none

module audio_front_end (
    input  wire                            audio_clk,
    input  wire                            rst_in,
    input  wire logic                      offset_trigger,
    input  wire audio_pkg::audio_sample_t  mic_in,
    output audio_pkg::audio_sample_t       processed,
    output audio_pkg::sample_t             offset_value,
    output logic                           offset_ready
);

    import audio_pkg::*;

    logic          measure_clear;
    logic          measure_en;
    logic          load_offset;
    logic          meas_done;
    audio_sample_t dc_out;

    offset_fsm u_offset_fsm (
        .audio_clk      (audio_clk),
        .rst_in         (rst_in),
        .offset_trigger (offset_trigger),
        .meas_done      (meas_done),
        .measure_clear  (measure_clear),
        .measure_en     (measure_en),
        .load_offset    (load_offset),
        .offset_ready   (offset_ready)
    );

    // terminal pulse on the 16th strobe of a measurement
    sample_counter #(
        .LIMIT     (OFFSET_SAMPLES)
    ) u_meas_counter (
        .audio_clk (audio_clk),
        .rst_in    (rst_in),
        .clear     (measure_clear),
        .count_en  (measure_en),
        .strobe    (mic_in.valid),
        .count     (),
        .wrap      (meas_done)
    );

    dc_offset_remover u_dc_offset_remover (
        .audio_clk     (audio_clk),
        .rst_in        (rst_in),
        .sample_in     (mic_in),
        .measure_clear (measure_clear),
        .measure_en    (measure_en),
        .load_offset   (load_offset),
        .offset_value  (offset_value),
        .dc_out        (dc_out)
    );

    // second register stage, output two cycles after a kept input
    antialias_decimator u_antialias_decimator (
        .audio_clk  (audio_clk),
        .rst_in     (rst_in),
        .sample_in  (dc_out),
        .sample_out (processed)
    );

endmodule

`default_nettype wire

//--- logic/antialias_decimator.sv
`timescale 1ns/1ns
`default_nettype none

module antialias_decimator (
    input  wire                            audio_clk,
    input  wire                            rst_in,
    input  wire audio_pkg::audio_sample_t  sample_in,
    output audio_pkg::audio_sample_t       sample_out
);

    import audio_pkg::*;

    // previous four samples, newest at index 0
    sample_t history [FIR_TAPS-1];

    // current sample plus history
    sample_t window [FIR_TAPS];

    logic signed [ACC_WIDTH-1:0]       weighted_sum;
    logic signed [ACC_WIDTH-1:0]       filtered;
    logic [$clog2(DECIM_FACTOR)-1:0]   phase;

    // decimation phase, advances once per filtered sample
    sample_counter #(
        .LIMIT     (DECIM_FACTOR)
    ) u_phase_counter (
        .audio_clk (audio_clk),
        .rst_in    (rst_in),
        .clear     (1'b0),
        .count_en  (1'b1),
        .strobe    (sample_in.valid),
        .count     (phase),
        .wrap      ()
    );

    always_comb begin
        window[0] = sample_in.data;
        for (int k = 1; k < FIR_TAPS; k++) begin
            window[k] = history[k-1];
        end
    end

    // coefficients widened with a zero sign bit so the product stays signed
    always_comb begin
        weighted_sum = '0;
        for (int k = 0; k < FIR_TAPS; k++) begin
            weighted_sum = weighted_sum + window[k] * $signed({1'b0, FIR_COEFS[k]});
        end
    end

    assign filtered = weighted_sum >>> FIR_SHIFT;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            for (int k = 0; k < FIR_TAPS - 1; k++) begin
                history[k] <= '0;
            end
        end else if (sample_in.valid) begin
            history[0] <= sample_in.data;
            for (int k = 1; k < FIR_TAPS - 1; k++) begin
                history[k] <= history[k-1];
            end
        end
    end

    // keep the 1st, 3rd, 5th ... filtered sample
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            sample_out.valid <= 1'b0;
        end else begin
            sample_out.valid <= sample_in.valid && (phase == '0);
        end
    end

    always_ff @(posedge audio_clk) begin
        if (sample_in.valid) begin
            sample_out.data <= saturate(filtered);
        end
    end

endmodule

`default_nettype wire

//--- logic/dc_offset_remover.sv
`timescale 1ns/1ns
`default_nettype none

module dc_offset_remover (
    input  wire                            audio_clk,
    input  wire                            rst_in,
    input  wire audio_pkg::audio_sample_t  sample_in,
    input  wire logic                      measure_clear,
    input  wire logic                      measure_en,
    input  wire logic                      load_offset,
    output audio_pkg::sample_t             offset_value,
    output audio_pkg::audio_sample_t       dc_out
);

    import audio_pkg::*;

    logic signed [ACC_WIDTH-1:0] acc;
    logic signed [ACC_WIDTH-1:0] sample_ext;
    logic signed [ACC_WIDTH-1:0] offset_ext;
    logic signed [ACC_WIDTH-1:0] avg;
    logic signed [ACC_WIDTH-1:0] diff;
    logic                        take_sample;

    // sign extension to the accumulator width
    assign sample_ext = sample_in.data;
    assign offset_ext = offset_value;

    assign take_sample = measure_en && sample_in.valid;

    // floor of sum / 16
    assign avg  = acc >>> OFFSET_LOG2_SAMPLES;
    assign diff = sample_ext - offset_ext;

    always_ff @(posedge audio_clk) begin
        if (measure_clear) begin
            acc <= take_sample ? sample_ext : '0;
        end else if (take_sample) begin
            acc <= acc + sample_ext;
        end
    end

    // old offset stays applied until the new one is loaded
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            offset_value <= '0;
        end else if (load_offset) begin
            offset_value <= avg[SAMPLE_WIDTH-1:0];
        end
    end

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            dc_out.valid <= 1'b0;
        end else begin
            dc_out.valid <= sample_in.valid;
        end
    end

    always_ff @(posedge audio_clk) begin
        if (sample_in.valid) begin
            dc_out.data <= saturate(diff);
        end
    end

endmodule

`default_nettype wire

//--- logic/offset_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module offset_fsm (
    input  wire        audio_clk,
    input  wire        rst_in,
    input  wire logic  offset_trigger,
    input  wire logic  meas_done,
    output logic       measure_clear,
    output logic       measure_en,
    output logic       load_offset,
    output logic       offset_ready
);

    import audio_pkg::*;

    fsm_state_t state;

    // accumulate only while a measurement runs
    assign measure_en = (state == MEASURE);

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state         <= IDLE;
            measure_clear <= 1'b0;
            load_offset   <= 1'b0;
            offset_ready  <= 1'b0;
        end else begin
            // both pulses last a single cycle
            measure_clear <= 1'b0;
            load_offset   <= 1'b0;

            // sticky once the first offset is held
            if (load_offset) begin
                offset_ready <= 1'b1;
            end

            case (state)
                IDLE, READY: begin
                    if (offset_trigger) begin
                        state         <= MEASURE;
                        measure_clear <= 1'b1;
                    end
                end
                MEASURE: begin
                    // triggers are ignored until the count completes
                    if (meas_done) begin
                        state       <= READY;
                        load_offset <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/sample_counter.sv
`timescale 1ns/1ns
`default_nettype none

module sample_counter #(
    parameter int LIMIT = 2
) (
    input  wire                       audio_clk,
    input  wire                       rst_in,
    input  wire logic                 clear,
    input  wire logic                 count_en,
    input  wire logic                 strobe,
    output logic [$clog2(LIMIT)-1:0]  count,
    output logic                      wrap
);

    localparam int CW = $clog2(LIMIT);

    logic advance;
    logic at_last;

    assign advance = count_en && strobe;
    assign at_last = (count == CW'(LIMIT - 1));

    // marks the strobe that takes the count back to zero
    assign wrap = advance && at_last && !clear;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            count <= '0;
        end else if (clear) begin
            // a strobe landing with the clear is the first one counted
            count <= advance ? CW'(1) : '0;
        end else if (advance) begin
            count <= at_last ? '0 : count + CW'(1);
        end
    end

endmodule

`default_nettype wire

//--- logic/audio_pkg.sv
`default_nettype none

package audio_pkg;

    localparam int SAMPLE_WIDTH = 16;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // one-cycle strobe with its payload
    typedef struct packed {
        logic    valid;
        sample_t data;
    } audio_sample_t;

    // offset measurement averages 2**4 samples
    localparam int OFFSET_LOG2_SAMPLES = 4;
    localparam int OFFSET_SAMPLES = 1 << OFFSET_LOG2_SAMPLES;

    // room for 16 full-scale samples, also used for the FIR sum
    localparam int ACC_WIDTH = 21;

    localparam int FIR_TAPS = 5;

    typedef logic [3:0] coef_t;

    // binomial taps, sum of 16 gives unity DC gain after FIR_SHIFT
    localparam coef_t FIR_COEFS [FIR_TAPS] = '{4'd1, 4'd4, 4'd6, 4'd4, 4'd1};
    localparam int FIR_SHIFT = 4;

    // 48 kHz down to 24 kHz
    localparam int DECIM_FACTOR = 2;

    typedef enum logic [1:0] {
        IDLE,
        MEASURE,
        READY
    } fsm_state_t;

    localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};

    // clamp a wide signed value into the 16-bit sample range
    function automatic sample_t saturate(input logic signed [ACC_WIDTH-1:0] value);
        if (value > SAMPLE_MAX) begin
            return SAMPLE_MAX;
        end else if (value < SAMPLE_MIN) begin
            return SAMPLE_MIN;
        end
        return value[SAMPLE_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire
